// File: lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    typedef logic [31:0] word_t;   // Data or address word
    typedef logic [7:0]  byte_t;

    // Access width code, byte count minus one
    typedef logic [1:0] width_t;

    localparam width_t width_byte = 2'd0;
    localparam width_t width_half = 2'd1;
    localparam width_t width_tri  = 2'd2;
    localparam width_t width_word = 2'd3;

    // Same 32 bits seen as one bus word or as four little-endian byte lanes
    typedef union packed {
        word_t          word;
        byte_t [3:0]    lanes;     // lanes[0] is the lowest address
    } lane_word_u;

    // Access unit FSM
    typedef enum logic [2:0] {
        idle,
        rd_first,                  // Read word holding the first byte
        rd_second,                 // Read following word on a crossing access
        wr_first,
        wr_second,
        respond                    // One-cycle response to the core
    } access_state_e;

endpackage

`default_nettype wire

// File: lane_align.sv
`timescale 1ns/1ps
`default_nettype none

module lane_align (
    input  wire lsu_pkg::word_t     low_word,
    input  wire lsu_pkg::word_t     high_word,
    input  wire [1:0]               offset,
    input  wire lsu_pkg::width_t    width,
    input  wire                     is_signed,
    input  wire lsu_pkg::word_t     store_data,
    output lsu_pkg::word_t          load_data,
    output lsu_pkg::word_t          merged_low,
    output lsu_pkg::word_t          merged_high
);

    lsu_pkg::lane_word_u low_u;
    lsu_pkg::lane_word_u high_u;
    lsu_pkg::lane_word_u store_u;
    lsu_pkg::lane_word_u raw_u;        // Bytes picked from the stream, not yet extended
    lsu_pkg::lane_word_u load_u;
    lsu_pkg::lane_word_u mlow_u;
    lsu_pkg::lane_word_u mhigh_u;

    logic [2:0] pos;                   // Position in the eight-byte stream
    logic [2:0] rel;                   // Stream position relative to the offset
    logic       sign_bit;
    logic       fill_bit;

    assign low_u.word   = low_word;
    assign high_u.word  = high_word;
    assign store_u.word = store_data;

    // Load path
    always_comb begin
        raw_u.word = '0;
        for (int i = 0; i < 4; i++) begin
            pos = {1'b0, offset} + 3'(i);
            raw_u.lanes[i] = pos[2] ? high_u.lanes[pos[1:0]] : low_u.lanes[pos[1:0]];
        end
    end

    assign sign_bit = raw_u.lanes[width][7];   // Top bit of the last valid byte
    assign fill_bit = is_signed && sign_bit;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            if (2'(i) <= width) begin
                load_u.lanes[i] = raw_u.lanes[i];
            end else begin
                load_u.lanes[i] = {8{fill_bit}};   // Zero or sign extension
            end
        end
    end

    assign load_data = load_u.word;

    // Store path, lanes outside the access keep the old memory bytes
    always_comb begin
        mlow_u  = low_u;
        mhigh_u = high_u;
        for (int i = 0; i < 4; i++) begin
            rel = 3'(i) - {1'b0, offset};
            if ((2'(i) >= offset) && (rel <= {1'b0, width})) begin
                mlow_u.lanes[i] = store_u.lanes[rel[1:0]];
            end
        end
        // High word only matters when the access runs past lane 3
        for (int i = 0; i < 4; i++) begin
            rel = 3'(i + 4) - {1'b0, offset};
            if (rel <= {1'b0, width}) begin
                mhigh_u.lanes[i] = store_u.lanes[rel[1:0]];
            end
        end
    end

    assign merged_low  = mlow_u.word;
    assign merged_high = mhigh_u.word;

endmodule

`default_nettype wire

// File: mem_access_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access_unit (
    input  wire                     clk,
    input  wire                     reset_n,

    // Core side
    input  wire                     req_valid,
    input  wire                     req_write,
    input  wire                     req_signed,
    input  wire lsu_pkg::width_t    req_width,
    input  wire lsu_pkg::word_t     req_addr,
    input  wire lsu_pkg::word_t     req_wdata,
    output logic                    req_ready,
    output logic                    rsp_valid,
    output lsu_pkg::word_t          rsp_rdata,

    // Word memory side
    output logic                    mem_req_valid,
    output logic                    mem_req_write,
    output logic [29:0]             mem_req_index,
    output lsu_pkg::word_t          mem_req_wdata,
    input  wire                     mem_req_ready,
    input  wire                     mem_rsp_valid,
    input  wire lsu_pkg::word_t     mem_rsp_rdata
);

    lsu_pkg::access_state_e state;
    lsu_pkg::access_state_e state_next;

    logic            issued;           // Word transaction accepted and awaiting its response
    logic            req_accept;
    logic            mem_accept;
    logic            full_store;
    logic            crosses;
    logic [29:0]     base_index;

    // Latched request
    logic            op_write;
    logic            op_signed;
    lsu_pkg::width_t op_width;
    lsu_pkg::word_t  op_addr;
    lsu_pkg::word_t  op_wdata;

    lsu_pkg::word_t  low_word;
    lsu_pkg::word_t  high_word;
    lsu_pkg::word_t  load_data;
    lsu_pkg::word_t  merged_low;
    lsu_pkg::word_t  merged_high;

    assign req_accept = req_valid && req_ready;
    assign mem_accept = mem_req_valid && mem_req_ready;

    // Aligned word store needs no read of the old word
    assign full_store = req_write && (req_addr[1:0] == 2'd0)
                        && (req_width == lsu_pkg::width_word);

    assign crosses    = ({1'b0, op_addr[1:0]} + {1'b0, op_width}) > 3'd3;
    assign base_index = op_addr[31:2];

    lane_align i_lane_align (
        .low_word    (low_word),
        .high_word   (high_word),
        .offset      (op_addr[1:0]),
        .width       (op_width),
        .is_signed   (op_signed),
        .store_data  (op_wdata),
        .load_data   (load_data),
        .merged_low  (merged_low),
        .merged_high (merged_high)
    );

    always_comb begin
        state_next = state;
        case (state)
            lsu_pkg::idle: begin
                if (req_accept) begin
                    state_next = full_store ? lsu_pkg::wr_first : lsu_pkg::rd_first;
                end
            end
            lsu_pkg::rd_first: begin
                if (mem_rsp_valid) begin
                    if (crosses) begin
                        state_next = lsu_pkg::rd_second;
                    end else if (op_write) begin
                        state_next = lsu_pkg::wr_first;     // Sub-word store goes on to merge
                    end else begin
                        state_next = lsu_pkg::respond;
                    end
                end
            end
            lsu_pkg::rd_second: begin
                if (mem_rsp_valid) begin
                    state_next = op_write ? lsu_pkg::wr_first : lsu_pkg::respond;
                end
            end
            lsu_pkg::wr_first: begin
                if (mem_rsp_valid) begin
                    state_next = crosses ? lsu_pkg::wr_second : lsu_pkg::respond;
                end
            end
            lsu_pkg::wr_second: begin
                if (mem_rsp_valid) begin
                    state_next = lsu_pkg::respond;
                end
            end
            lsu_pkg::respond: state_next = lsu_pkg::idle;
            default:          state_next = lsu_pkg::idle;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state  <= lsu_pkg::idle;
            issued <= 1'b0;
        end else begin
            state <= state_next;
            if (mem_accept) begin
                issued <= 1'b1;
            end else if (mem_rsp_valid) begin
                issued <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_accept) begin
            op_write  <= req_write;
            op_signed <= req_signed;
            op_width  <= req_width;
            op_addr   <= req_addr;
            op_wdata  <= req_wdata;
        end
        if (mem_rsp_valid && (state == lsu_pkg::rd_first)) begin
            low_word <= mem_rsp_rdata;
        end
        if (mem_rsp_valid && (state == lsu_pkg::rd_second)) begin
            high_word <= mem_rsp_rdata;
        end
    end

    assign req_ready = (state == lsu_pkg::idle);
    assign rsp_valid = (state == lsu_pkg::respond);
    assign rsp_rdata = (rsp_valid && !op_write) ? load_data : '0;   // Stores return zero

    assign mem_req_valid = !issued && (state inside {lsu_pkg::rd_first, lsu_pkg::rd_second,
                                                     lsu_pkg::wr_first, lsu_pkg::wr_second});
    assign mem_req_write = (state inside {lsu_pkg::wr_first, lsu_pkg::wr_second});
    assign mem_req_index = (state inside {lsu_pkg::rd_second, lsu_pkg::wr_second})
                           ? base_index + 30'd1 : base_index;
    assign mem_req_wdata = (state == lsu_pkg::wr_second) ? merged_high : merged_low;

    a_rsp_single_cycle: assert property (
        @(posedge clk) disable iff (!reset_n)
        rsp_valid |=> !rsp_valid
    );

    // Core is held off while a word transaction is outstanding
    a_busy_not_ready: assert property (
        @(posedge clk) disable iff (!reset_n)
        issued |-> !req_ready
    );

    a_req_stable: assert property (
        @(posedge clk) disable iff (!reset_n)
        (mem_req_valid && !mem_req_ready) |=>
            (mem_req_valid && $stable(mem_req_write) && $stable(mem_req_index)
             && $stable(mem_req_wdata))
    );

endmodule

`default_nettype wire

// File: word_ram.sv
`timescale 1ns/1ps
`default_nettype none

module word_ram #(
    parameter int MEM_WORDS   = 256,
    parameter int MEM_LATENCY = 2
) (
    input  wire                     clk,
    input  wire                     reset_n,
    input  wire                     mem_req_valid,
    input  wire                     mem_req_write,
    input  wire [29:0]              mem_req_index,
    input  wire lsu_pkg::word_t     mem_req_wdata,
    output logic                    mem_req_ready,
    output logic                    mem_rsp_valid,
    output lsu_pkg::word_t          mem_rsp_rdata
);

    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int CNT_W = $clog2(MEM_LATENCY + 2);

    lsu_pkg::word_t   mem [MEM_WORDS];

    logic             busy;
    logic [CNT_W-1:0] wait_cnt;        // Wait states left
    logic             accept;
    logic             done;

    logic             held_write;
    logic [IDX_W-1:0] held_index;
    lsu_pkg::word_t   held_wdata;

    assign accept        = mem_req_valid && mem_req_ready;
    assign done          = busy && (wait_cnt == '0);
    assign mem_req_ready = !busy;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy          <= 1'b0;
            wait_cnt      <= '0;
            mem_rsp_valid <= 1'b0;
        end else begin
            mem_rsp_valid <= 1'b0;
            if (accept) begin
                busy     <= 1'b1;
                wait_cnt <= CNT_W'(MEM_LATENCY);
            end else if (done) begin
                busy          <= 1'b0;
                mem_rsp_valid <= 1'b1;
            end else if (busy) begin
                wait_cnt <= wait_cnt - 1'b1;
            end
        end
    end

    // Array access happens when the wait states run out
    always_ff @(posedge clk) begin
        if (accept) begin
            held_write <= mem_req_write;
            held_index <= IDX_W'(mem_req_index % MEM_WORDS);   // Index wraps at the RAM depth
            held_wdata <= mem_req_wdata;
        end
        if (done) begin
            if (held_write) begin
                mem[held_index] <= held_wdata;
            end else begin
                mem_rsp_rdata <= mem[held_index];
            end
        end
    end

    // Requester must wait for the response before presenting the next word
    a_no_req_while_busy: assert property (
        @(posedge clk) disable iff (!reset_n)
        busy |-> !mem_req_valid
    );

    a_rsp_follows_accept: assert property (
        @(posedge clk) disable iff (!reset_n)
        accept |=> ##(MEM_LATENCY + 1) mem_rsp_valid
    );

endmodule

`default_nettype wire

// File: mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem #(
    parameter int MEM_WORDS   = 256,   // RAM depth in words
    parameter int MEM_LATENCY = 2      // Wait states per word transaction
) (
    input  wire                     clk,
    input  wire                     reset_n,
    input  wire                     req_valid,
    input  wire                     req_write,
    input  wire                     req_signed,
    input  wire lsu_pkg::width_t    req_width,
    input  wire lsu_pkg::word_t     req_addr,
    input  wire lsu_pkg::word_t     req_wdata,
    output logic                    req_ready,
    output logic                    rsp_valid,
    output lsu_pkg::word_t          rsp_rdata
);

    // Word bus between access unit and RAM
    wire                    mem_req_valid;
    wire                    mem_req_write;
    wire [29:0]             mem_req_index;
    wire lsu_pkg::word_t    mem_req_wdata;
    wire                    mem_req_ready;
    wire                    mem_rsp_valid;
    wire lsu_pkg::word_t    mem_rsp_rdata;

    mem_access_unit i_access_unit (
        .clk           (clk),
        .reset_n       (reset_n),
        .req_valid     (req_valid),
        .req_write     (req_write),
        .req_signed    (req_signed),
        .req_width     (req_width),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .req_ready     (req_ready),
        .rsp_valid     (rsp_valid),
        .rsp_rdata     (rsp_rdata),
        .mem_req_valid (mem_req_valid),
        .mem_req_write (mem_req_write),
        .mem_req_index (mem_req_index),
        .mem_req_wdata (mem_req_wdata),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_rdata (mem_rsp_rdata)
    );

    word_ram #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) i_word_ram (
        .clk           (clk),
        .reset_n       (reset_n),
        .mem_req_valid (mem_req_valid),
        .mem_req_write (mem_req_write),
        .mem_req_index (mem_req_index),
        .mem_req_wdata (mem_req_wdata),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_rdata (mem_rsp_rdata)
    );

endmodule

`default_nettype wire

// File: tb_access_table.svh
`ifndef tb_access_table_svh
`define tb_access_table_svh

    // Columns: write, signed, width code, byte address, store data, expected read data
    // Width code is the byte count minus one, and stores read back zero
    localparam int access_count = 32;

    localparam logic [99:0] access_table [access_count] = '{
        {1'b1, 1'b0, 2'd3, 32'h0000_0000, 32'h1122_3344, 32'h0000_0000},   // Word stores
        {1'b1, 1'b0, 2'd3, 32'h0000_0004, 32'h5566_7788, 32'h0000_0000},
        {1'b1, 1'b0, 2'd3, 32'h0000_0008, 32'h99aa_bbcc, 32'h0000_0000},
        {1'b1, 1'b0, 2'd3, 32'h0000_000c, 32'hddee_ff00, 32'h0000_0000},
        {1'b1, 1'b0, 2'd0, 32'h0000_0000, 32'h0000_00a0, 32'h0000_0000},   // Byte at each offset
        {1'b1, 1'b0, 2'd0, 32'h0000_0005, 32'h0000_00b5, 32'h0000_0000},
        {1'b1, 1'b0, 2'd0, 32'h0000_000a, 32'h0000_00ca, 32'h0000_0000},
        {1'b1, 1'b0, 2'd0, 32'h0000_000f, 32'h0000_00df, 32'h0000_0000},
        {1'b1, 1'b0, 2'd1, 32'h0000_0002, 32'h0000_beef, 32'h0000_0000},
        {1'b1, 1'b0, 2'd1, 32'h0000_0006, 32'h0000_1234, 32'h0000_0000},
        {1'b0, 1'b0, 2'd3, 32'h0000_0000, 32'h0000_0000, 32'hbeef_33a0},   // Neighbours kept
        {1'b0, 1'b0, 2'd3, 32'h0000_0004, 32'h0000_0000, 32'h1234_b588},
        {1'b0, 1'b0, 2'd3, 32'h0000_0008, 32'h0000_0000, 32'h99ca_bbcc},
        {1'b0, 1'b0, 2'd3, 32'h0000_000c, 32'h0000_0000, 32'hdfee_ff00},
        {1'b0, 1'b1, 2'd0, 32'h0000_0003, 32'h0000_0000, 32'hffff_ffbe},   // Sign extension
        {1'b0, 1'b0, 2'd0, 32'h0000_0003, 32'h0000_0000, 32'h0000_00be},
        {1'b0, 1'b1, 2'd1, 32'h0000_0002, 32'h0000_0000, 32'hffff_beef},
        {1'b0, 1'b0, 2'd1, 32'h0000_0002, 32'h0000_0000, 32'h0000_beef},
        {1'b0, 1'b0, 2'd3, 32'h0000_0002, 32'h0000_0000, 32'hb588_beef},   // Crossing loads
        {1'b0, 1'b1, 2'd1, 32'h0000_0003, 32'h0000_0000, 32'hffff_88be},
        {1'b0, 1'b0, 2'd2, 32'h0000_0003, 32'h0000_0000, 32'h00b5_88be},
        {1'b1, 1'b0, 2'd3, 32'h0000_0007, 32'hcafe_f00d, 32'h0000_0000},   // Crossing stores
        {1'b0, 1'b0, 2'd3, 32'h0000_0005, 32'h0000_0000, 32'hf00d_34b5},
        {1'b1, 1'b0, 2'd1, 32'h0000_000b, 32'h0000_7654, 32'h0000_0000},
        {1'b0, 1'b0, 2'd3, 32'h0000_000a, 32'h0000_0000, 32'hff76_54ca},
        {1'b1, 1'b0, 2'd2, 32'h0000_0006, 32'h00ab_cdef, 32'h0000_0000},
        {1'b0, 1'b1, 2'd2, 32'h0000_0006, 32'h0000_0000, 32'hffab_cdef},
        {1'b0, 1'b0, 2'd3, 32'h0000_0004, 32'h0000_0000, 32'hcdef_b588},
        {1'b1, 1'b0, 2'd2, 32'h0000_000b, 32'h0066_5544, 32'h0000_0000},
        {1'b0, 1'b1, 2'd2, 32'h0000_000b, 32'h0000_0000, 32'h0066_5544},
        {1'b0, 1'b0, 2'd3, 32'h0000_0008, 32'h0000_0000, 32'h44ca_feab},
        {1'b0, 1'b0, 2'd3, 32'h0000_000c, 32'h0000_0000, 32'hdfee_6655}
    };

`endif

// File: tb_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;

    localparam int mem_words    = 256;
    localparam int mem_latency  = 2;
    localparam int wait_limit   = 100;     // Cycles allowed for any single wait
    localparam int random_count = 300;

    logic            clk = 1'b0;
    logic            reset_n;
    logic            req_valid;
    logic            req_write;
    logic            req_signed;
    lsu_pkg::width_t req_width;
    lsu_pkg::word_t  req_addr;
    lsu_pkg::word_t  req_wdata;
    logic            req_ready;
    logic            rsp_valid;
    lsu_pkg::word_t  rsp_rdata;

    lsu_pkg::byte_t  model [mem_words*4];  // Byte image of the RAM, little-endian
    logic [31:0]     lcg_state;

    `include "tb_access_table.svh"

    mem_subsystem #(
        .MEM_WORDS   (mem_words),
        .MEM_LATENCY (mem_latency)
    ) i_dut (
        .clk        (clk),
        .reset_n    (reset_n),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .req_signed (req_signed),
        .req_width  (req_width),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_ready  (req_ready),
        .rsp_valid  (rsp_valid),
        .rsp_rdata  (rsp_rdata)
    );

    always #50 clk = ~clk;

    task automatic stop_run();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input lsu_pkg::word_t got, input lsu_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s returned %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input bit got, input bit exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %0b, expected %0b", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (!req_ready) begin
            @(negedge clk);
            cycles++;
            if (cycles > wait_limit) begin
                $display("The DUT never raised req_ready, stopped at %0t ns", $time);
                stop_run();
            end
        end
    endtask

    task automatic wait_response();
        int cycles;
        cycles = 0;
        while (!rsp_valid) begin
            check_flag(req_ready, 1'b0, "req_ready while busy");
            @(negedge clk);
            cycles++;
            if (cycles > wait_limit) begin
                $display("The DUT never raised rsp_valid, stopped at %0t ns", $time);
                stop_run();
            end
        end
    endtask

    // One request from handshake to response, called on a falling edge
    task automatic run_access(input logic write, input logic is_signed,
                              input lsu_pkg::width_t width, input lsu_pkg::word_t addr,
                              input lsu_pkg::word_t wdata, output lsu_pkg::word_t rdata);
        wait_ready();
        req_valid  = 1'b1;
        req_write  = write;
        req_signed = is_signed;
        req_width  = width;
        req_addr   = addr;
        req_wdata  = wdata;
        @(negedge clk);                    // Taken on the rising edge in between
        req_valid  = 1'b0;
        check_flag(req_ready, 1'b0, "req_ready after acceptance");
        wait_response();
        rdata = rsp_rdata;
        @(negedge clk);
        check_flag(rsp_valid, 1'b0, "rsp_valid after the response cycle");
        check_flag(req_ready, 1'b1, "req_ready after the response cycle");
    endtask

    task automatic model_store(input lsu_pkg::word_t addr, input lsu_pkg::width_t width,
                               input lsu_pkg::word_t wdata);
        for (int k = 0; k <= int'(width); k++) begin
            model[(addr + k) % (mem_words * 4)] = wdata[8*k +: 8];
        end
    endtask

    function automatic lsu_pkg::word_t model_load(input lsu_pkg::word_t addr,
                                                  input lsu_pkg::width_t width,
                                                  input logic is_signed);
        lsu_pkg::word_t value;
        lsu_pkg::byte_t last;
        value = '0;
        last  = '0;
        for (int k = 0; k <= int'(width); k++) begin
            last = model[(addr + k) % (mem_words * 4)];
            value[8*k +: 8] = last;
        end
        if (is_signed && last[7]) begin
            for (int k = int'(width) + 1; k < 4; k++) begin
                value[8*k +: 8] = 8'hff;
            end
        end
        return value;
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    initial begin
        lsu_pkg::word_t  rdata;
        lsu_pkg::word_t  expect_data;
        logic [99:0]     entry;
        logic [31:0]     r;
        logic            wr;
        logic            sg;
        lsu_pkg::width_t wd;
        lsu_pkg::word_t  ad;
        lsu_pkg::word_t  wdat;

        reset_n    = 1'b0;
        req_valid  = 1'b0;
        req_write  = 1'b0;
        req_signed = 1'b0;
        req_width  = lsu_pkg::width_byte;
        req_addr   = '0;
        req_wdata  = '0;
        lcg_state  = 32'd66;
        repeat (8) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        check_flag(req_ready, 1'b1, "req_ready after reset");
        check_flag(rsp_valid, 1'b0, "rsp_valid after reset");

        for (int i = 0; i < access_count; i++) begin
            entry = access_table[i];
            run_access(entry[99], entry[98], entry[97:96], entry[95:64], entry[63:32], rdata);
            check_word(rdata, entry[31:0], $sformatf("table entry %0d", i));
        end

        // Whole RAM gets a known pattern before random loads
        for (int w = 0; w < mem_words; w++) begin
            ad   = 4 * w;
            wdat = (ad + 32'd1) * 32'h9e37_79b1;
            run_access(1'b1, 1'b0, lsu_pkg::width_word, ad, wdat, rdata);
            check_word(rdata, '0, "fill store");
            model_store(ad, lsu_pkg::width_word, wdat);
        end

        for (int n = 0; n < random_count; n++) begin
            r    = lcg_next();
            wr   = r[31];
            sg   = r[30];
            wd   = r[29:28];
            ad   = (lcg_next() >> 12) % (mem_words * 4);
            wdat = lcg_next();
            run_access(wr, sg, wd, ad, wdat, rdata);
            if (wr) begin
                model_store(ad, wd, wdat);
                expect_data = '0;
            end else begin
                expect_data = model_load(ad, wd, sg);
            end
            check_word(rdata, expect_data, $sformatf("random access %0d at %h", n, ad));
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
lsu_pkg.sv
lane_align.sv
mem_access_unit.sv
word_ram.sv
mem_subsystem.sv
tb_mem_subsystem.sv

// File: Bender.yml
package:
  name: mem_subsystem

sources:
  - lsu_pkg.sv
  - lane_align.sv
  - mem_access_unit.sv
  - word_ram.sv
  - mem_subsystem.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_mem_subsystem.sv
